/* Bender.yml */
package:
  name: arcade_io

sources:
  - verilog/arcade_pkg.sv
  - verilog/ps2_receiver.sv
  - verilog/key_decoder.sv
  - verilog/control_mapper.sv
  - verilog/sigma_delta_dac.sv
  - verilog/video_blank_expand.sv
  - verilog/arcade_io_top.sv
  - target: test
    files:
      - testbench/tb_arcade_io.sv

/* testbench/tb_arcade_io.sv */
/*
 * Arcade I/O testbench
 * Random PS/2, pad, audio and video stimulus for the top level, checked
 * against a reference model of the control, DAC and video rules
 */

`timescale 1ns/1ps

module tb_arcade_io;

	import arcade_pkg::*;

	// The limit leaves margin over three DAC windows of 65536 cycles plus
	// about 75000 cycles of keyboard frames and the short pad and video runs
	localparam int CYCLE_LIMIT = 300000;
	localparam int PS2_HALF    = 20;
	localparam int NUM_PAD     = 200;

	logic       clk_sys;
	logic       arst_n;
	logic       ps2_clk;
	logic       ps2_data;
	pad_t       pad0;
	pad_t       pad1;
	logic       upright;
	logic       test_mode;
	video_in_t  core_video;
	logic [3:0] core_audio;
	player_in_t player_in;
	joy_dir_t   joy_dir;
	video_out_t vga;
	logic       audio_l;
	logic       audio_r;

	logic [31:0] lcg_state = 32'd30;
	int          cycle_cnt = 0;
	int          strobe_cnt = 0;
	logic [7:0]  last_code;

	// Reference model of the key decoder
	key_state_t  model_keys;
	logic        model_ext;
	logic        model_brk;

	// Pad cases that the upright run replays
	pad_t        case_pad0 [NUM_PAD];
	pad_t        case_pad1 [NUM_PAD];
	logic        case_test [NUM_PAD];

	arcade_io_top DUT (
		.clk_sys_i    (clk_sys),
		.arst_n_i     (arst_n),
		.ps2_clk_i    (ps2_clk),
		.ps2_data_i   (ps2_data),
		.pad0_i       (pad0),
		.pad1_i       (pad1),
		.upright_i    (upright),
		.test_mode_i  (test_mode),
		.core_video_i (core_video),
		.core_audio_i (core_audio),
		.player_in_o  (player_in),
		.joy_dir_o    (joy_dir),
		.vga_o        (vga),
		.audio_l_o    (audio_l),
		.audio_r_o    (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Counts scan strobes and keeps the byte that came with the last one
	always @(posedge clk_sys) begin
		if (DUT.scan_valid) begin
			strobe_cnt = strobe_cnt + 1;
			last_code  = DUT.scan_code;
		end
	end

	always @(posedge clk_sys) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("Timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
			report_failure();
		end
	end

	// ========================================
	// Helpers
	// ========================================

	task automatic report_failure();
		$display("*** FAILED ***");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("ERR %s got %h expected %h", name, got, exp);
			report_failure();
		end
	endtask

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		// The low bits of this generator repeat quickly and are dropped
		return {8'h00, lcg_state[31:8]};
	endfunction

	// Inputs change 1 ns after the rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk_sys);
		#1;
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		wait_cycles(16);
		arst_n     = 1'b1;
		model_keys = '0;
		model_ext  = 1'b0;
		model_brk  = 1'b0;
	endtask

	// Start bit, eight data bits LSB first, odd parity, stop bit
	task automatic send_ps2_frame(input logic [7:0] code, input logic bad_parity);
		logic [10:0] frame;
		int          i;
		frame = {1'b1, ~(^code) ^ bad_parity, code, 1'b0};
		for (i = 0; i < 11; i++) begin
			ps2_data = frame[i];
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b0;
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b1;
		end
		ps2_data = 1'b1;
	endtask

	// ========================================
	// Reference model
	// ========================================

	task automatic model_scan_byte(input logic [7:0] code);
		logic held;
		held = ~model_brk;
		if (code == SC_EXTENDED) begin
			model_ext = 1'b1;
		end else if (code == SC_BREAK) begin
			model_brk = 1'b1;
		end else begin
			if (model_ext) begin
				if (code == SC_LEFT)  model_keys.left  = held;
				if (code == SC_RIGHT) model_keys.right = held;
				if (code == SC_DOWN)  model_keys.down  = held;
				if (code == SC_UP)    model_keys.up    = held;
			end else begin
				if (code == SC_SPACE) model_keys.fire   = held;
				if (code == SC_KEY1)  model_keys.start1 = held;
				if (code == SC_KEY2)  model_keys.start2 = held;
				if (code == SC_KEY5)  model_keys.coin   = held;
			end
			model_ext = 1'b0;
			model_brk = 1'b0;
		end
	endtask

	function automatic player_in_t expect_player(input key_state_t k, input pad_t p0,
		input pad_t p1, input logic tm);
		player_in_t e;
		// Cabinet bits that nothing drives stay released
		e        = '1;
		e.test   = ~tm;
		e.c_coin = ~k.coin;
		e.start1 = ~k.start1;
		e.start2 = ~k.start2;
		e.fire1  = ~(k.fire | ~p0.fire1 | ~p1.fire1);
		e.fire2  = ~(k.fire | ~p0.fire2 | ~p1.fire2);
		return e;
	endfunction

	function automatic joy_dir_t expect_joy(input key_state_t k, input pad_t p0,
		input pad_t p1, input logic turn);
		logic     u;
		logic     d;
		logic     l;
		logic     r;
		joy_dir_t e;
		u = k.up    | ~p0.up    | ~p1.up;
		d = k.down  | ~p0.down  | ~p1.down;
		l = k.left  | ~p0.left  | ~p1.left;
		r = k.right | ~p0.right | ~p1.right;
		if (turn) begin
			e = '{right: ~u, left: ~d, down: ~r, up: ~l};
		end else begin
			e = '{right: ~r, left: ~l, down: ~d, up: ~u};
		end
		return e;
	endfunction

	function automatic video_out_t expect_video(input video_in_t v);
		video_out_t e;
		e.colour = '0;
		if (!(v.hblank || v.vblank)) begin
			e.colour.r = {2{v.colour.r}};
			e.colour.g = {2{v.colour.g}};
			e.colour.b = {2{v.colour.b}};
		end
		e.hsync = v.hsync;
		e.vsync = v.vsync;
		return e;
	endfunction

	function automatic logic [7:0] code_of_key(input int idx);
		case (idx)
			0:       return SC_SPACE;
			1:       return SC_KEY1;
			2:       return SC_KEY2;
			3:       return SC_KEY5;
			4:       return SC_LEFT;
			5:       return SC_RIGHT;
			6:       return SC_DOWN;
			7:       return SC_UP;
			default: return 8'h1C;
		endcase
	endfunction

	task automatic check_controls();
		check_value("player_in_o", player_in,
			expect_player(model_keys, pad0, pad1, test_mode));
		check_value("joy_dir_o", joy_dir, expect_joy(model_keys, pad0, pad1, upright));
	endtask

	task automatic send_scan_byte(input logic [7:0] code);
		int strobes_before;
		int waited;
		strobes_before = strobe_cnt;
		waited         = 0;
		send_ps2_frame(code, 1'b0);
		while (strobe_cnt == strobes_before && waited < 100) begin
			wait_cycles(1);
			waited++;
		end
		assert (strobe_cnt == strobes_before + 1) else begin
			$display("Expected one scan strobe for PS/2 byte %h, saw %0d",
				code, strobe_cnt - strobes_before);
			report_failure();
		end
		check_value("scan_code", last_code, code);
		model_scan_byte(code);
		wait_cycles(2);
		check_controls();
	endtask

	task automatic send_bad_frame(input logic [7:0] code);
		int strobes_before;
		strobes_before = strobe_cnt;
		send_ps2_frame(code, 1'b1);
		wait_cycles(20);
		assert (strobe_cnt == strobes_before) else begin
			$display("A PS/2 frame with bad parity raised a scan strobe");
			report_failure();
		end
		check_controls();
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [7:0]  code;
		int          idx;
		int          ones;

		ps2_clk    = 1'b1;
		ps2_data   = 1'b1;
		pad0       = '1;
		pad1       = '1;
		upright    = 1'b0;
		test_mode  = 1'b0;
		core_video = '0;
		core_audio = '0;
		apply_reset();

		// Keyboard sequences with a corrupted frame in front of some of them
		for (int n = 0; n < 40; n++) begin
			rnd  = next_random();
			rnd2 = next_random();
			idx  = rnd % 9;
			code = code_of_key(idx);
			if (rnd2[1:0] == 2'd0) send_bad_frame(code);
			if (((idx >= 4) && (idx < 8)) ^ (rnd2[4:2] == 3'd0)) send_scan_byte(SC_EXTENDED);
			if (rnd2[5]) send_scan_byte(SC_BREAK);
			send_scan_byte(code);
		end

		apply_reset();
		for (int n = 0; n < NUM_PAD; n++) begin
			rnd          = next_random();
			case_pad0[n] = rnd[5:0];
			case_pad1[n] = rnd[11:6];
			case_test[n] = rnd[12];
		end

		// The same pad cases run first normal and then rotated
		for (int pass = 0; pass < 2; pass++) begin
			upright = pass[0];
			for (int n = 0; n < NUM_PAD; n++) begin
				pad0      = case_pad0[n];
				pad1      = case_pad1[n];
				test_mode = case_test[n];
				wait_cycles(2);
				check_controls();
			end
		end

		for (int n = 0; n < 500; n++) begin
			rnd        = next_random();
			core_video = rnd[12:0];
			wait_cycles(1);
			check_value("vga_o", vga, expect_video(core_video));
		end

		// Each DAC window starts from a cleared accumulator
		for (int w = 0; w < 3; w++) begin
			rnd        = next_random();
			core_audio = rnd[3:0];
			apply_reset();
			ones = 0;
			for (int k = 0; k < 65536; k++) begin
				wait_cycles(1);
				check_value("audio_r_o", audio_r, audio_l);
				ones = ones + audio_l;
			end
			check_value("audio_l_o ones", ones, {4{core_audio}});
		end

		$display("*** PASSED ***");
		$finish;
	end

endmodule

/* verilog/arcade_io_top.sv */
/*
 * Arcade I/O top level
 * Platform glue for the game core: keyboard and pad controls in,
 * video and audio out, all on the system clock
 */

`timescale 1ns/1ps

module arcade_io_top (
	input  logic                   clk_sys_i,
	input  logic                   arst_n_i,
	input  logic                   ps2_clk_i,
	input  logic                   ps2_data_i,
	input  arcade_pkg::pad_t       pad0_i,
	input  arcade_pkg::pad_t       pad1_i,
	input  logic                   upright_i,
	input  logic                   test_mode_i,
	input  arcade_pkg::video_in_t  core_video_i,
	input  logic [3:0]             core_audio_i,
	output arcade_pkg::player_in_t player_in_o,
	output arcade_pkg::joy_dir_t   joy_dir_o,
	output arcade_pkg::video_out_t vga_o,
	output logic                   audio_l_o,
	output logic                   audio_r_o
);

	import arcade_pkg::*;

	logic [7:0] scan_code;
	logic       scan_valid;
	key_state_t key_state;

	// ========================================
	// Controls
	// ========================================

	ps2_receiver ps2_receiver (
		.clk_sys_i    (clk_sys_i),
		.arst_n_i     (arst_n_i),
		.ps2_clk_i    (ps2_clk_i),
		.ps2_data_i   (ps2_data_i),
		.scan_code_o  (scan_code),
		.scan_valid_o (scan_valid)
	);

	key_decoder key_decoder (
		.clk_sys_i    (clk_sys_i),
		.arst_n_i     (arst_n_i),
		.scan_code_i  (scan_code),
		.scan_valid_i (scan_valid),
		.key_state_o  (key_state)
	);

	control_mapper control_mapper (
		.clk_sys_i   (clk_sys_i),
		.arst_n_i    (arst_n_i),
		.key_state_i (key_state),
		.pad0_i      (pad0_i),
		.pad1_i      (pad1_i),
		.upright_i   (upright_i),
		.test_mode_i (test_mode_i),
		.player_in_o (player_in_o),
		.joy_dir_o   (joy_dir_o)
	);

	// ========================================
	// Audio and video
	// ========================================

	sigma_delta_dac sigma_delta_dac (
		.clk_sys_i (clk_sys_i),
		.arst_n_i  (arst_n_i),
		.sample_i  (core_audio_i),
		.dac_o     (audio_l_o)
	);

	// Mono core, both channels carry the same stream
	assign audio_r_o = audio_l_o;

	video_blank_expand video_blank_expand (
		.clk_sys_i (clk_sys_i),
		.arst_n_i  (arst_n_i),
		.video_i   (core_video_i),
		.video_o   (vga_o)
	);

endmodule

/* verilog/arcade_pkg.sv */
/*
 * Arcade I/O package
 * Shared types and constants for the platform glue around the game core:
 * pad, key and control words, colour and video bundles, DAC width and
 * PS/2 scan codes
 */

package arcade_pkg;

	// ========================================
	// Control words
	// ========================================

	// One gamepad, all levels active low
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire1;
		logic fire2;
	} pad_t;

	// Keys currently held on the keyboard, active high
	typedef struct packed {
		logic fire;
		logic start1;
		logic start2;
		logic coin;
		logic left;
		logic right;
		logic down;
		logic up;
	} key_state_t;

	// Joystick word seen by the core, active low
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
	} joy_dir_t;

	// Player inputs seen by the core, active low, MSB first as the core expects
	typedef struct packed {
		logic r_coin;
		logic c_coin;
		logic l_coin;
		logic test;
		logic cocktail;
		logic slam;
		logic start2;
		logic start1;
		logic fire1;
		logic fire2;
	} player_in_t;

	// ========================================
	// Video
	// ========================================

	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} rgb3_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb6_t;

	typedef struct packed {
		rgb3_t colour;
		logic  hsync;
		logic  vsync;
		logic  hblank;
		logic  vblank;
	} video_in_t;

	typedef struct packed {
		rgb6_t colour;
		logic  hsync;
		logic  vsync;
	} video_out_t;

	// ========================================
	// Constants
	// ========================================

	// Top bit of the sigma-delta input word
	localparam int DAC_MSBI = 15;

	// Set 2 scan codes, the arrows only count after the extended prefix
	localparam logic [7:0] SC_EXTENDED = 8'hE0;
	localparam logic [7:0] SC_BREAK    = 8'hF0;
	localparam logic [7:0] SC_SPACE    = 8'h29;
	localparam logic [7:0] SC_KEY1     = 8'h16;
	localparam logic [7:0] SC_KEY2     = 8'h1E;
	localparam logic [7:0] SC_KEY5     = 8'h2E;
	localparam logic [7:0] SC_LEFT     = 8'h6B;
	localparam logic [7:0] SC_RIGHT    = 8'h74;
	localparam logic [7:0] SC_DOWN     = 8'h72;
	localparam logic [7:0] SC_UP       = 8'h75;

endpackage

/* verilog/control_mapper.sv */
/*
 * Control mapper
 * Merges keyboard and two pads into the core's active-low player and
 * joystick words, with an optional direction rotation for upright cabinets
 */

`timescale 1ns/1ps

module control_mapper (
	input  logic                   clk_sys_i,
	input  logic                   arst_n_i,
	input  arcade_pkg::key_state_t key_state_i,
	input  arcade_pkg::pad_t       pad0_i,
	input  arcade_pkg::pad_t       pad1_i,
	input  logic                   upright_i,
	input  logic                   test_mode_i,
	output arcade_pkg::player_in_t player_in_o,
	output arcade_pkg::joy_dir_t   joy_dir_o
);

	import arcade_pkg::*;

	// Pressed levels, active high
	logic     up_p, down_p, left_p, right_p;
	logic     fire1_p, fire2_p;
	joy_dir_t joy_nxt;

	// Registered player bits that actually move
	logic     c_coin_q, start2_q, start1_q, fire1_q, fire2_q;
	logic     test_q;

	assign up_p    = key_state_i.up    | ~pad0_i.up    | ~pad1_i.up;
	assign down_p  = key_state_i.down  | ~pad0_i.down  | ~pad1_i.down;
	assign left_p  = key_state_i.left  | ~pad0_i.left  | ~pad1_i.left;
	assign right_p = key_state_i.right | ~pad0_i.right | ~pad1_i.right;
	// Space fires both buttons
	assign fire1_p = key_state_i.fire  | ~pad0_i.fire1 | ~pad1_i.fire1;
	assign fire2_p = key_state_i.fire  | ~pad0_i.fire2 | ~pad1_i.fire2;

	// Upright cabinets mount the monitor turned, so the stick turns with it
	always_comb begin
		joy_nxt.up    = upright_i ? ~left_p  : ~up_p;
		joy_nxt.down  = upright_i ? ~right_p : ~down_p;
		joy_nxt.left  = upright_i ? ~down_p  : ~left_p;
		joy_nxt.right = upright_i ? ~up_p    : ~right_p;
	end

	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			joy_dir_o <= '1;
			c_coin_q  <= 1'b1;
			start2_q  <= 1'b1;
			start1_q  <= 1'b1;
			fire1_q   <= 1'b1;
			fire2_q   <= 1'b1;
		end else begin
			joy_dir_o <= joy_nxt;
			c_coin_q  <= ~key_state_i.coin;
			start2_q  <= ~key_state_i.start2;
			start1_q  <= ~key_state_i.start1;
			fire1_q   <= ~fire1_p;
			fire2_q   <= ~fire2_p;
		end
	end

	// The test switch tracks its input even while reset is held
	always_ff @(posedge clk_sys_i) begin
		test_q <= ~test_mode_i;
	end

	// Unused coin slots, cocktail and slam tilt stay released
	assign player_in_o = '{r_coin: 1'b1, c_coin: c_coin_q, l_coin: 1'b1,
		test: test_q, cocktail: 1'b1, slam: 1'b1, start2: start2_q,
		start1: start1_q, fire1: fire1_q, fire2: fire2_q};

endmodule

/* verilog/key_decoder.sv */
/*
 * Key decoder
 * Follows the extended and break prefixes of the scan code stream and
 * keeps one held level for each of the eight keys the game uses
 */

`timescale 1ns/1ps

module key_decoder (
	input  logic                   clk_sys_i,
	input  logic                   arst_n_i,
	input  logic [7:0]             scan_code_i,
	input  logic                   scan_valid_i,
	output arcade_pkg::key_state_t key_state_o
);

	import arcade_pkg::*;

	logic ext_q;
	logic brk_q;
	logic make;

	// A byte after F0 releases the key, anything else presses it
	assign make = ~brk_q;

	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ext_q       <= 1'b0;
			brk_q       <= 1'b0;
			key_state_o <= '0;
		end else if (scan_valid_i) begin
			if (scan_code_i == SC_EXTENDED) begin
				ext_q <= 1'b1;
			end else if (scan_code_i == SC_BREAK) begin
				brk_q <= 1'b1;
			end else begin
				// Any other byte ends the prefix sequence
				ext_q <= 1'b0;
				brk_q <= 1'b0;

				if (ext_q) begin
					// ========================================
					// Extended set: cursor keys
					// ========================================
					case (scan_code_i)
						SC_LEFT:  key_state_o.left  <= make;
						SC_RIGHT: key_state_o.right <= make;
						SC_DOWN:  key_state_o.down  <= make;
						SC_UP:    key_state_o.up    <= make;
						default:  ;
					endcase
				end else begin
					case (scan_code_i)
						SC_SPACE: key_state_o.fire   <= make;
						SC_KEY1:  key_state_o.start1 <= make;
						SC_KEY2:  key_state_o.start2 <= make;
						SC_KEY5:  key_state_o.coin   <= make;
						default:  ;
					endcase
				end
			end
		end
	end

endmodule

/* verilog/ps2_receiver.sv */
/*
 * PS/2 receiver
 * Synchronises the keyboard clock and data lines, shifts in 11-bit frames
 * on falling clock edges and emits each checked byte with a one-cycle strobe
 */

`timescale 1ns/1ps

module ps2_receiver (
	input  logic       clk_sys_i,
	input  logic       arst_n_i,
	input  logic       ps2_clk_i,
	input  logic       ps2_data_i,
	output logic [7:0] scan_code_o,
	output logic       scan_valid_o
);

	// Two synchroniser stages plus one history bit on the clock line
	logic [2:0]  clk_sync_q;
	logic [1:0]  data_sync_q;
	logic        clk_fall;
	logic        data_s;

	// Start, data and parity bits, LSB first; the stop bit is checked live
	logic [9:0]  shift_q;
	logic [3:0]  bit_cnt_q;
	logic [12:0] idle_cnt_q;
	logic        frame_ok;

	assign clk_fall = clk_sync_q[2] & ~clk_sync_q[1];
	assign data_s   = data_sync_q[1];

	// Start low, stop high, odd parity over data and parity bit
	assign frame_ok = ~shift_q[0] & data_s & (^shift_q[9:1]);

	// Both lines idle high, so the synchronisers reset to ones
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			clk_sync_q  <= '1;
			data_sync_q <= '1;
		end else begin
			clk_sync_q  <= {clk_sync_q[1:0], ps2_clk_i};
			data_sync_q <= {data_sync_q[0], ps2_data_i};
		end
	end

	// ========================================
	// Frame counter, timeout and strobe
	// ========================================

	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			bit_cnt_q    <= '0;
			idle_cnt_q   <= '0;
			scan_valid_o <= 1'b0;
		end else begin
			scan_valid_o <= 1'b0;
			if (clk_fall) begin
				idle_cnt_q <= '0;
				if (bit_cnt_q == 4'd10) begin
					bit_cnt_q    <= '0;
					scan_valid_o <= frame_ok;
				end else begin
					bit_cnt_q <= bit_cnt_q + 4'd1;
				end
			end else if (idle_cnt_q[12]) begin
				// Line went quiet mid-frame, start over at the next start bit
				bit_cnt_q <= '0;
			end else begin
				idle_cnt_q <= idle_cnt_q + 13'd1;
			end
		end
	end

	// Payload path
	always_ff @(posedge clk_sys_i) begin
		if (clk_fall) begin
			if (bit_cnt_q != 4'd10) begin
				shift_q <= {data_s, shift_q[9:1]};
			end else begin
				scan_code_o <= shift_q[8:1];
			end
		end
	end

endmodule

/* verilog/sigma_delta_dac.sv */
/*
 * Sigma-delta audio DAC
 * Repeats the 4-bit sample to the full DAC width and drives a first-order
 * accumulator whose carry gives a one-bit pulse-density stream
 */

`timescale 1ns/1ps

module sigma_delta_dac (
	input  logic       clk_sys_i,
	input  logic       arst_n_i,
	input  logic [3:0] sample_i,
	output logic       dac_o
);

	import arcade_pkg::*;

	logic [DAC_MSBI:0]   dac_in;
	logic [DAC_MSBI:0]   acc_q;
	logic [DAC_MSBI+1:0] sum;

	// Repeating the nibble maps 0..F onto 0..FFFF evenly
	assign dac_in = {4{sample_i}};
	assign sum    = {1'b0, acc_q} + {1'b0, dac_in};

	// The carry out fires dac_in times per full turn of the accumulator
	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q <= '0;
			dac_o <= 1'b0;
		end else begin
			acc_q <= sum[DAC_MSBI:0];
			dac_o <= sum[DAC_MSBI+1];
		end
	end

endmodule

/* verilog/video_blank_expand.sv */
/*
 * Video blank and expand
 * Forces black during blanking, widens 3-bit colour to 6 bits and
 * registers colour and sync together
 */

`timescale 1ns/1ps

module video_blank_expand (
	input  logic                   clk_sys_i,
	input  logic                   arst_n_i,
	input  arcade_pkg::video_in_t  video_i,
	output arcade_pkg::video_out_t video_o
);

	import arcade_pkg::*;

	logic  visible;
	rgb6_t colour_wide;

	assign visible = ~(video_i.hblank | video_i.vblank);

	// Bit repetition keeps full white at full scale
	always_comb begin
		colour_wide.r = {video_i.colour.r, video_i.colour.r};
		colour_wide.g = {video_i.colour.g, video_i.colour.g};
		colour_wide.b = {video_i.colour.b, video_i.colour.b};
	end

	always_ff @(posedge clk_sys_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			video_o <= '0;
		end else begin
			video_o.colour <= visible ? colour_wide : '0;
			video_o.hsync  <= video_i.hsync;
			video_o.vsync  <= video_i.vsync;
		end
	end

endmodule

/* vlog.f */
verilog/arcade_pkg.sv
verilog/ps2_receiver.sv
verilog/key_decoder.sv
verilog/control_mapper.sv
verilog/sigma_delta_dac.sv
verilog/video_blank_expand.sv
verilog/arcade_io_top.sv
testbench/tb_arcade_io.sv
